// File: list.f
common/ili9341_pkg.sv
spi/spi_master.sv
controller/init_rom.sv
controller/ili9341_sequencer.sv
verilog/delay_timer.sv
verilog/pixel_serializer.sv
verilog/ili9341_controller.sv
tests/tb_ili9341.sv

// File: tests/ili9341_vectors.txt
// Link words as {dc, value} in hex, dc=0 command, dc=1 parameter
// After the FFFF marker: RGB565 pixel values to stream, in order
001                     // Software reset
0CB 139 12C 100 134 102 // Power control A
0CF 100 1C1 130         // Power control B
0E8 185 100 178         // Driver timing A
0EA 100 100             // Driver timing B
0ED 164 103 112 181     // Power-on sequence
0F7 120                 // Pump ratio
0C0 123                 // Power control 1
0C1 110                 // Power control 2
0C5 13E 128             // VCOM 1
0C7 186                 // VCOM 2
036 148                 // MADCTL portrait
037 100                 // Vertical scroll start
03A 155                 // 16 bits per pixel
0B1 100 118             // Frame rate
0B6 108 182 127         // Display function
0F2 100                 // 3-gamma off
026 101                 // Gamma curve 1
011                     // Sleep out
029                     // Display on
036 1E8                 // MX MY MV BGR
02A 100 100 101 13F     // Columns 0 to 319
02B 100 100 100 1EF     // Pages 0 to 239
02C                     // Memory write
FFFF                    // End of link words
F800 07E0 001F FFFF
0000 1234 ABCD 5A5A

// File: tests/tb_ili9341.sv
// ILI9341 controller testbench
`timescale 1ns/1ps
module tb_ili9341;
    localparam int DELAY_CYCLES = 40;
    localparam int SCK_HALF     = 1;
    localparam int INIT_WORDS   = 66;    // Reset, table, Display On, rotation, window
    localparam int STREAM_PIX   = 12;    // File pixels, then random ones
    localparam int WAIT_LIMIT   = 5000;  // Clocks per wait
    localparam int CNT_WORDS    = 0;
    localparam int CNT_FALLS    = 1;
    localparam int CNT_RISES    = 2;

    logic        clk = 1'b0;
    logic        rst;
    logic [15:0] input_data;
    logic        frame_done;
    logic        spi_mosi;
    logic        spi_sck;
    logic        spi_cs;
    logic        spi_dc;
    logic        data_clk;

    logic [15:0] vec [0:127];
    logic [8:0]  exp_q [$];       // Words still to come off the wire
    integer      seed;
    logic [31:0] rnd;
    int          errs [1:6];
    int          checks, tests_passed, tests_failed;
    int          n_words, cs_falls, dclk_rises, gap_checks;
    int          cycle_cnt, last_end, bit_cnt;
    int          pix_test, pix_idx, pix_base, n_file_pix;
    bit          timed_out;
    bit          word_seen;
    logic        cs_q, sck_q, dclk_q, dc_cap;
    logic [7:0]  shreg;
    logic [8:0]  word_now, last_word;
    logic [15:0] cur_pix;

    ili9341_controller #(.DELAY_CYCLES(DELAY_CYCLES), .SCK_HALF(SCK_HALF)) dut0 (
        .clk(clk), .rst(rst), .input_data(input_data), .frame_done(frame_done),
        .spi_mosi(spi_mosi), .spi_sck(spi_sck), .spi_cs(spi_cs), .spi_dc(spi_dc),
        .data_clk(data_clk)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    task automatic check_value(input int test, input string name,
                               input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        assert (actual === expected)
        else begin
            $display("FAILED %s: expected %0h, got %0h", name, expected, actual);
            errs[test]++;
        end
    endtask

    task automatic check_condition(input int test, input bit cond, input string msg);
        checks++;
        assert (cond)
        else begin
            $display("%s", msg);
            errs[test]++;
        end
    endtask

    task automatic wait_for_count(input int test, input int sel, input int n, input string what);
        int t;
        int cnt;
        t = 0;
        cnt = (sel == CNT_WORDS) ? n_words : (sel == CNT_FALLS) ? cs_falls : dclk_rises;
        while (!timed_out && cnt < n) begin
            @(posedge clk);
            t++;
            cnt = (sel == CNT_WORDS) ? n_words : (sel == CNT_FALLS) ? cs_falls : dclk_rises;
            if (t >= WAIT_LIMIT) begin
                $display("Timeout while waiting for %s", what);
                errs[test]++;
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic report_test(input int test, input string name);
        if (errs[test] == 0) begin
            tests_passed++;
            $display("Test %0d %s: PASS", test, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: FAIL with %0d errors", test, name, errs[test]);
        end
    endtask

    task automatic queue_pixel(input logic [15:0] p);
        exp_q.push_back({1'b1, p[15:8]});  // High byte first
        exp_q.push_back({1'b1, p[7:0]});
    endtask

    function automatic int test_of_word(input int idx);
        if (idx == 0) return 2;
        if (idx <= 52) return 3;
        if (idx < INIT_WORDS) return 4;
        return pix_test;
    endfunction

    // --------------------
    // SPI decoder and pixel source
    // --------------------
    always @(negedge clk) begin
        cycle_cnt++;
        if (!word_seen && spi_cs !== 1'b0) begin
            check_value(1, "spi_cs", 32'h1, 32'(spi_cs));
            check_value(1, "spi_sck", 32'h0, 32'(spi_sck));
            check_value(1, "data_clk", 32'h0, 32'(data_clk));
        end
        if (cs_q && !spi_cs) begin
            if (!word_seen) begin
                check_condition(1, rst === 1'b1, "spi_cs fell while reset was held");
            end
            if (n_words == 1 || n_words == 52 || n_words == 53) begin
                gap_checks++;  // First word after each wait
                check_condition(2, cycle_cnt - last_end >= DELAY_CYCLES,
                                "A word started before the power-up wait ended");
            end
            word_seen = 1'b1;
            cs_falls++;
            bit_cnt = 0;
        end
        if (!spi_cs && spi_sck && !sck_q) begin
            shreg = {shreg[6:0], spi_mosi};
            bit_cnt++;
        end
        if (!spi_cs) dc_cap = spi_dc;
        if (!cs_q && spi_cs) begin
            word_now = {dc_cap, shreg};
            check_value(test_of_word(n_words), "spi_sck rising edges", 32'd8, bit_cnt);
            if (exp_q.size() == 0) begin
                check_condition(test_of_word(n_words), 1'b0, "A word arrived with none expected");
            end else begin
                check_value(test_of_word(n_words), "spi_dc", 32'(exp_q[0][8]), 32'(word_now[8]));
                check_value(test_of_word(n_words), "spi_mosi byte",
                            32'(exp_q[0][7:0]), 32'(word_now[7:0]));
                void'(exp_q.pop_front());
            end
            last_word = word_now;
            last_end  = cycle_cnt;
            n_words++;
        end
        if (!dclk_q && data_clk) dclk_rises++;
        if (dclk_q && !data_clk) begin  // Pixel used up, present the next
            if (pix_idx < n_file_pix) begin
                cur_pix = vec[pix_base + pix_idx];
            end else begin
                rnd     = $random(seed);
                cur_pix = rnd[15:0];
            end
            pix_idx++;
            input_data = cur_pix;
            queue_pixel(cur_pix);
        end
        cs_q   = spi_cs;
        sck_q  = spi_sck;
        dclk_q = data_clk;
    end

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        int i;
        int w0;
        int f0;
        logic [15:0] held;
        seed = 32'hdd78;
        rst = 1'b0;
        frame_done = 1'b0;
        input_data = 16'h0000;
        cs_q = 1'b1;
        sck_q = 1'b0;
        dclk_q = 1'b0;
        pix_test = 5;
        for (i = 1; i <= 6; i++) errs[i] = 0;
        $readmemh("tests/ili9341_vectors.txt", vec);
        i = 0;
        while (i < 128 && !$isunknown(vec[i]) && vec[i] <= 16'h01FF) begin
            exp_q.push_back(vec[i][8:0]);
            i++;
        end
        check_condition(3, exp_q.size() == INIT_WORDS, "Vectors file has a wrong word count");
        pix_base = i + 1;  // Skip the marker
        while (pix_base + n_file_pix < 128 && !$isunknown(vec[pix_base + n_file_pix]))
            n_file_pix++;
        cur_pix = (n_file_pix > 0) ? vec[pix_base] : 16'h0000;
        pix_idx = 1;
        input_data = cur_pix;
        queue_pixel(cur_pix);
        repeat (10) @(negedge clk);
        rst = 1'b1;

        wait_for_count(1, CNT_FALLS, 1, "the first word");
        report_test(1, "idle after reset");
        wait_for_count(3, CNT_WORDS, 53, "the end of Display On");
        report_test(3, "configuration table");
        wait_for_count(2, CNT_FALLS, 54, "the start of MADCTL");
        check_value(2, "wait checks", 32'd3, gap_checks);
        report_test(2, "reset command and waits");
        wait_for_count(4, CNT_WORDS, INIT_WORDS, "the end of RAMWR");
        report_test(4, "rotation and window");
        wait_for_count(5, CNT_WORDS, INIT_WORDS + 2 * STREAM_PIX, "the streamed pixels");
        check_value(5, "data_clk rising edges", STREAM_PIX, dclk_rises);
        report_test(5, "pixel streaming");

        // Pause just after a high byte, its low byte is never sent
        pix_test = 6;
        wait_for_count(6, CNT_RISES, dclk_rises + 1, "a high byte to be taken");
        w0 = n_words;
        @(negedge clk);
        frame_done = 1'b1;
        void'(exp_q.pop_back());
        wait_for_count(6, CNT_WORDS, w0 + 1, "the word in flight");
        f0 = cs_falls;
        repeat (3 * DELAY_CYCLES) @(posedge clk);
        check_condition(6, cs_falls == f0, "A word started while frame_done was high");
        check_value(6, "data_clk", 32'h0, 32'(dclk_q));
        held = cur_pix;
        @(negedge clk);
        frame_done = 1'b0;
        wait_for_count(6, CNT_WORDS, w0 + 2, "the first word after the pause");
        check_value(6, "first word after pause", 32'({1'b1, held[15:8]}), 32'(last_word));
        wait_for_count(6, CNT_WORDS, w0 + 4, "the held pixel");
        report_test(6, "frame pause");

        $display("Tests passed %0d, failed %0d, checks %0d", tests_passed, tests_failed, checks);
        if (tests_failed == 0 && !timed_out) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: verilog/ili9341_controller.sv
// ILI9341 SPI display controller
`timescale 1ns/1ps
module ili9341_controller #(
    parameter int DELAY_CYCLES = 2500000,  // 100 ms at 25 MHz
    parameter int SCK_HALF     = 1
) (
    input  logic                clk,
    input  logic                rst,
    input  ili9341_pkg::pixel_t input_data,
    input  logic                frame_done,
    output logic                spi_mosi,
    output logic                spi_sck,
    output logic                spi_cs,
    output logic                spi_dc,
    output logic                data_clk
);
    import ili9341_pkg::*;

    lcd_word_t                     tx_word;
    lcd_word_t                     rom_word;
    lcd_word_t                     pixel_word;
    logic [$clog2(INIT_LEN)-1:0]   rom_addr;
    logic                          tx_valid;
    logic                          idle;
    logic                          wait_en;
    logic                          delay_done;
    logic                          take_byte;
    logic                          frame_pause;

    ili9341_sequencer seq0 (
        .clk(clk), .rst(rst), .idle(idle), .delay_done(delay_done),
        .frame_done(frame_done), .rom_word(rom_word), .pixel_word(pixel_word),
        .tx_word(tx_word), .tx_valid(tx_valid), .rom_addr(rom_addr),
        .wait_en(wait_en), .take_byte(take_byte), .frame_pause(frame_pause)
    );

    init_rom rom0 (.rom_addr(rom_addr), .rom_word(rom_word));

    delay_timer #(.DELAY_CYCLES(DELAY_CYCLES)) delay0 (
        .clk(clk), .rst(rst), .wait_en(wait_en), .delay_done(delay_done)
    );

    pixel_serializer pix0 (
        .clk(clk), .rst(rst), .input_data(input_data), .take_byte(take_byte),
        .frame_pause(frame_pause), .pixel_word(pixel_word), .data_clk(data_clk)
    );

    spi_master #(.SCK_HALF(SCK_HALF)) spi0 (
        .clk(clk), .rst(rst), .tx_word(tx_word), .tx_valid(tx_valid), .idle(idle),
        .spi_mosi(spi_mosi), .spi_sck(spi_sck), .spi_cs(spi_cs), .spi_dc(spi_dc)
    );

endmodule

// File: verilog/pixel_serializer.sv
// Pixel to byte splitter
`timescale 1ns/1ps
module pixel_serializer (
    input  logic                   clk,
    input  logic                   rst,
    input  ili9341_pkg::pixel_t    input_data,
    input  logic                   take_byte,
    input  logic                   frame_pause,
    output ili9341_pkg::lcd_word_t pixel_word,
    output logic                   data_clk
);
    logic low_next;  // Low byte goes out next

    always_ff @(posedge clk) begin
        if (!rst) begin
            low_next <= 1'b0;
        end else if (frame_pause) begin
            low_next <= 1'b0;  // Frames restart on a pixel boundary
        end else if (take_byte) begin
            low_next <= !low_next;
        end
    end

    assign pixel_word = low_next ? {1'b1, input_data[7:0]} : {1'b1, input_data[15:8]};
    assign data_clk   = low_next;  // Falls when the pixel is used up

endmodule

// File: verilog/delay_timer.sv
// Power-up wait counter
`timescale 1ns/1ps
module delay_timer #(
    parameter int DELAY_CYCLES = 2500000
) (
    input  logic clk,
    input  logic rst,
    input  logic wait_en,
    output logic delay_done
);
    localparam int CNT_W = $clog2(DELAY_CYCLES + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DELAY_CYCLES - 1);

    logic [CNT_W-1:0] count;  // Clocks since wait_en rose

    always_ff @(posedge clk) begin
        if (!rst) begin
            count      <= '0;
            delay_done <= 1'b0;
        end else if (!wait_en) begin
            count      <= '0;
            delay_done <= 1'b0;
        end else begin
            delay_done <= (count == CNT_LAST);
            if (count <= CNT_LAST) begin
                count <= count + 1'b1;  // Saturates, one pulse per wait
            end
        end
    end

endmodule

// File: controller/ili9341_sequencer.sv
// ILI9341 power-up and frame sequencer
`timescale 1ns/1ps
module ili9341_sequencer (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     idle,
    input  logic                                     delay_done,
    input  logic                                     frame_done,
    input  ili9341_pkg::lcd_word_t                   rom_word,
    input  ili9341_pkg::lcd_word_t                   pixel_word,
    output ili9341_pkg::lcd_word_t                   tx_word,
    output logic                                     tx_valid,
    output logic [$clog2(ili9341_pkg::INIT_LEN)-1:0] rom_addr,
    output logic                                     wait_en,
    output logic                                     take_byte,
    output logic                                     frame_pause
);
    import ili9341_pkg::*;

    localparam int IDX_W = $clog2(INIT_LEN);
    localparam logic [7:0] ROTATION = MADCTL_MX | MADCTL_MY | MADCTL_MV | MADCTL_BGR;

    seq_state_t state, state_next;
    logic [IDX_W-1:0] idx;       // Table index, also rotation/window step
    lcd_word_t        win_word;
    logic             send;      // A word is offered this cycle
    logic             step_end;  // Index restarts after this word

    // --------------------
    // Rotation and window words
    // --------------------
    always_comb begin
        case (idx[3:0])
            4'd0:    win_word = {1'b0, CMD_CASET};
            4'd3:    win_word = {1'b1, COL_END[15:8]};
            4'd4:    win_word = {1'b1, COL_END[7:0]};
            4'd5:    win_word = {1'b0, CMD_PASET};
            4'd8:    win_word = {1'b1, PAGE_END[15:8]};
            4'd9:    win_word = {1'b1, PAGE_END[7:0]};
            4'd10:   win_word = {1'b0, CMD_RAMWR};
            default: win_word = {1'b1, 8'h00};  // Start column and page
        endcase
    end

    // --------------------
    // Next state and word select
    // --------------------
    always_comb begin
        state_next = state;
        send       = 1'b0;
        step_end   = 1'b1;
        tx_word    = {1'b0, CMD_SWRESET};
        case (state)
            START:       state_next = SEND_RESET;
            SEND_RESET: begin
                send = 1'b1;
                if (idle) state_next = WAIT_RESET;
            end
            WAIT_RESET:  if (delay_done) state_next = SEND_CONFIG;
            SEND_CONFIG: begin
                send     = 1'b1;
                tx_word  = rom_word;
                step_end = (idx == IDX_W'(INIT_LEN - 1));
                if (idle && step_end) state_next = WAIT_CONFIG;
            end
            WAIT_CONFIG: if (delay_done) state_next = DISPLAY_ON;
            DISPLAY_ON: begin
                send    = 1'b1;
                tx_word = {1'b0, CMD_DISPON};
                if (idle) state_next = WAIT_ON;
            end
            WAIT_ON:     if (delay_done) state_next = SET_ROTATION;
            SET_ROTATION: begin
                send     = 1'b1;
                step_end = idx[0];
                tx_word  = idx[0] ? {1'b1, ROTATION} : {1'b0, CMD_MADCTL};
                if (idle && step_end) state_next = SET_WINDOW;
            end
            SET_WINDOW: begin
                send     = 1'b1;
                step_end = (idx == IDX_W'(10));
                tx_word  = win_word;
                if (idle && step_end) state_next = FRAME_LOOP;
            end
            FRAME_LOOP: begin
                send    = !frame_done;  // Hold off new words in a pause
                tx_word = pixel_word;
                if (frame_done) state_next = WAIT_FRAME;
            end
            WAIT_FRAME:  if (!frame_done) state_next = FRAME_LOOP;
            default:     state_next = START;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= START;
            idx   <= '0;
        end else begin
            state <= state_next;
            if (tx_valid) begin
                idx <= step_end ? '0 : idx + 1'b1;
            end
        end
    end

    assign tx_valid    = send && idle;
    assign take_byte   = tx_valid && (state == FRAME_LOOP);
    assign frame_pause = (state == WAIT_FRAME);
    assign rom_addr    = idx;
    // Waits start once the last word has left the wire
    assign wait_en     = idle && (state inside {WAIT_RESET, WAIT_CONFIG, WAIT_ON});

    a_state_legal : assert property (@(posedge clk) disable iff (!rst)
        state inside {[START:WAIT_FRAME]});
    a_rom_in_range : assert property (@(posedge clk) disable iff (!rst)
        (state == SEND_CONFIG) |-> (rom_addr < INIT_LEN));

endmodule

// File: controller/init_rom.sv
// ILI9341 configuration table
`timescale 1ns/1ps
module init_rom (
    input  logic [$clog2(ili9341_pkg::INIT_LEN)-1:0] rom_addr,
    output ili9341_pkg::lcd_word_t                   rom_word
);
    import ili9341_pkg::*;

    always_comb begin
        case (rom_addr)
            6'd0:  rom_word = {1'b0, CMD_POWERA};
            6'd1:  rom_word = {1'b1, 8'h39};
            6'd2:  rom_word = {1'b1, 8'h2C};
            6'd3:  rom_word = {1'b1, 8'h00};
            6'd4:  rom_word = {1'b1, 8'h34};
            6'd5:  rom_word = {1'b1, 8'h02};  // VBC 1.6 V
            6'd6:  rom_word = {1'b0, CMD_POWERB};
            6'd7:  rom_word = {1'b1, 8'h00};
            6'd8:  rom_word = {1'b1, 8'hC1};
            6'd9:  rom_word = {1'b1, 8'h30};
            6'd10: rom_word = {1'b0, CMD_DTCA};
            6'd11: rom_word = {1'b1, 8'h85};
            6'd12: rom_word = {1'b1, 8'h00};
            6'd13: rom_word = {1'b1, 8'h78};
            6'd14: rom_word = {1'b0, CMD_DTCB};
            6'd15: rom_word = {1'b1, 8'h00};
            6'd16: rom_word = {1'b1, 8'h00};
            6'd17: rom_word = {1'b0, CMD_POWER_SEQ};
            6'd18: rom_word = {1'b1, 8'h64};
            6'd19: rom_word = {1'b1, 8'h03};
            6'd20: rom_word = {1'b1, 8'h12};
            6'd21: rom_word = {1'b1, 8'h81};
            6'd22: rom_word = {1'b0, CMD_PRC};
            6'd23: rom_word = {1'b1, 8'h20};  // DDVDH = 2xVCI
            6'd24: rom_word = {1'b0, CMD_PWCTR1};
            6'd25: rom_word = {1'b1, 8'h23};  // GVDD 4.6 V
            6'd26: rom_word = {1'b0, CMD_PWCTR2};
            6'd27: rom_word = {1'b1, 8'h10};
            6'd28: rom_word = {1'b0, CMD_VMCTR1};
            6'd29: rom_word = {1'b1, 8'h3E};
            6'd30: rom_word = {1'b1, 8'h28};
            6'd31: rom_word = {1'b0, CMD_VMCTR2};
            6'd32: rom_word = {1'b1, 8'h86};
            6'd33: rom_word = {1'b0, CMD_MADCTL};
            6'd34: rom_word = {1'b1, 8'h48};  // Portrait, rewritten later
            6'd35: rom_word = {1'b0, CMD_VSCRADD};
            6'd36: rom_word = {1'b1, 8'h00};
            6'd37: rom_word = {1'b0, CMD_COLMOD};
            6'd38: rom_word = {1'b1, 8'h55};  // 16 bits per pixel
            6'd39: rom_word = {1'b0, CMD_FRMCTR1};
            6'd40: rom_word = {1'b1, 8'h00};
            6'd41: rom_word = {1'b1, 8'h18};  // 79 Hz
            6'd42: rom_word = {1'b0, CMD_DISCTRL};
            6'd43: rom_word = {1'b1, 8'h08};
            6'd44: rom_word = {1'b1, 8'h82};
            6'd45: rom_word = {1'b1, 8'h27};
            6'd46: rom_word = {1'b0, CMD_3GAMMA_EN};
            6'd47: rom_word = {1'b1, 8'h00};  // 3-gamma off
            6'd48: rom_word = {1'b0, CMD_GAMMASET};
            6'd49: rom_word = {1'b1, 8'h01};
            6'd50: rom_word = {1'b0, CMD_SLPOUT};
            default: rom_word = {1'b0, 8'h00};
        endcase
    end

endmodule

// File: spi/spi_master.sv
// SPI master for 9-bit link words
`timescale 1ns/1ps
module spi_master #(
    parameter int SCK_HALF = 1
) (
    input  logic                   clk,
    input  logic                   rst,
    input  ili9341_pkg::lcd_word_t tx_word,
    input  logic                   tx_valid,
    output logic                   idle,
    output logic                   spi_mosi,
    output logic                   spi_sck,
    output logic                   spi_cs,
    output logic                   spi_dc
);
    localparam int DIV_W = (SCK_HALF > 1) ? $clog2(SCK_HALF) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SCK_HALF - 1);

    logic [7:0]       shift_q;   // Byte on the wire, MSB first
    logic [DIV_W-1:0] div_cnt;   // Clocks within a half period
    logic [3:0]       half_cnt;  // SCK half periods sent
    logic             half_end;
    logic             start;

    assign start    = tx_valid && idle;
    assign half_end = !spi_cs && (div_cnt == DIV_LAST);
    assign spi_mosi = !spi_cs && shift_q[7];  // Quiet low between words

    // --------------------
    // Framing and SCK
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            idle     <= 1'b1;
            spi_cs   <= 1'b1;
            spi_sck  <= 1'b0;
            spi_dc   <= 1'b0;
            div_cnt  <= '0;
            half_cnt <= '0;
        end else if (start) begin
            idle     <= 1'b0;
            spi_cs   <= 1'b0;
            spi_dc   <= tx_word.dc;  // Steady for the whole word
            div_cnt  <= '0;
            half_cnt <= '0;
        end else if (!spi_cs) begin
            if (half_end) begin
                div_cnt  <= '0;
                half_cnt <= half_cnt + 4'd1;
                spi_sck  <= !spi_sck;
                if (half_cnt == 4'd15) begin
                    spi_cs <= 1'b1;  // Last falling edge closes the word
                end
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end else begin
            idle <= 1'b1;  // One cycle after cs rises
        end
    end

    // Shift on SCK falling so mosi is stable at each rising edge
    always_ff @(posedge clk) begin
        if (start) begin
            shift_q <= tx_word.value;
        end else if (half_end && spi_sck) begin
            shift_q <= {shift_q[6:0], 1'b0};
        end
    end

    a_valid_when_idle : assert property (@(posedge clk) disable iff (!rst)
        tx_valid |-> idle);
    a_cs_high_when_idle : assert property (@(posedge clk) disable iff (!rst)
        idle |-> spi_cs);

endmodule

// File: common/ili9341_pkg.sv
// ILI9341 shared definitions
package ili9341_pkg;

    // --------------------
    // Link word and pixel
    // --------------------
    typedef struct packed {
        logic       dc;     // 0 command, 1 parameter or pixel data
        logic [7:0] value;
    } lcd_word_t;

    typedef logic [15:0] pixel_t;  // RGB565

    // --------------------
    // Command codes
    // --------------------
    localparam logic [7:0] CMD_SWRESET   = 8'h01;
    localparam logic [7:0] CMD_SLPOUT    = 8'h11;
    localparam logic [7:0] CMD_GAMMASET  = 8'h26;
    localparam logic [7:0] CMD_DISPON    = 8'h29;
    localparam logic [7:0] CMD_CASET     = 8'h2A;
    localparam logic [7:0] CMD_PASET     = 8'h2B;
    localparam logic [7:0] CMD_RAMWR     = 8'h2C;
    localparam logic [7:0] CMD_MADCTL    = 8'h36;
    localparam logic [7:0] CMD_VSCRADD   = 8'h37;
    localparam logic [7:0] CMD_COLMOD    = 8'h3A;
    localparam logic [7:0] CMD_FRMCTR1   = 8'hB1;
    localparam logic [7:0] CMD_DISCTRL   = 8'hB6;
    localparam logic [7:0] CMD_PWCTR1    = 8'hC0;
    localparam logic [7:0] CMD_PWCTR2    = 8'hC1;
    localparam logic [7:0] CMD_VMCTR1    = 8'hC5;
    localparam logic [7:0] CMD_VMCTR2    = 8'hC7;
    localparam logic [7:0] CMD_POWERA    = 8'hCB;
    localparam logic [7:0] CMD_POWERB    = 8'hCF;
    localparam logic [7:0] CMD_DTCA      = 8'hE8;
    localparam logic [7:0] CMD_DTCB      = 8'hEA;
    localparam logic [7:0] CMD_POWER_SEQ = 8'hED;
    localparam logic [7:0] CMD_3GAMMA_EN = 8'hF2;
    localparam logic [7:0] CMD_PRC       = 8'hF7;

    // --------------------
    // MADCTL bits
    // --------------------
    localparam logic [7:0] MADCTL_MY  = 8'h80;  // Bottom to top
    localparam logic [7:0] MADCTL_MX  = 8'h40;  // Right to left
    localparam logic [7:0] MADCTL_MV  = 8'h20;  // Row/column exchange
    localparam logic [7:0] MADCTL_BGR = 8'h08;

    // Last column and page of the landscape window
    localparam logic [15:0] COL_END  = 16'h013F;
    localparam logic [15:0] PAGE_END = 16'h00EF;

    localparam int INIT_LEN = 51;  // Config table entries

    typedef enum logic [3:0] {
        START,
        SEND_RESET,
        WAIT_RESET,
        SEND_CONFIG,
        WAIT_CONFIG,
        DISPLAY_ON,
        WAIT_ON,
        SET_ROTATION,
        SET_WINDOW,
        FRAME_LOOP,
        WAIT_FRAME
    } seq_state_t;

endpackage
